// File: flist.f
+incdir+bench
common/t08_pkg.sv
src/handler/t08_handler.sv
src/memory/t08_sram.sv
src/t08_periph_reg.sv
src/t08_mem_decode.sv
src/t08_mem_top.sv
bench/t08_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the t08 memory path testbench with verilator and run it
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module t08_mem_tb \
    --Mdir obj_dir \
    -o t08_mem_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/t08_mem_sim 2>&1 | tee "$LOG" \
    || { echo "simulation exited with an error"; exit 1; }

grep -q "TEST FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "no result found in $LOG"; exit 1; }
echo "simulation passed"
exit 0

// File: bench/t08_mem_model.svh
// **********************************************************************
// t08 memory path testbench model
// word array, peripheral word, lane merge and load extension,
// plus the fibonacci lfsr that feeds the stimulus
// **********************************************************************

`ifndef T08_MEM_MODEL_SVH
`define T08_MEM_MODEL_SVH

t08_pkg::word_t model_mem [512]; // mirror of the ram words
t08_pkg::word_t model_periph;    // mirror of the i2c register
logic [15:0]    lfsr_q;          // x^16 + x^14 + x^13 + x^11 + 1

// n fresh bits, one lfsr step per bit
function automatic t08_pkg::word_t rand_bits(input int n);
    t08_pkg::word_t v;
    logic           fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        v      = {v[30:0], fb}; // shift the new bit in
    end
    return v;
endfunction

// bits a store touches, always the low lanes
function automatic t08_pkg::word_t lane_mask(input t08_pkg::func3_t f3);
    case (f3)
        t08_pkg::F3_B: return 32'h0000_00ff;
        t08_pkg::F3_H: return 32'h0000_ffff;
        default:       return 32'hffff_ffff;
    endcase
endfunction

// cut to byte or half, then fill the top for signed sizes
function automatic t08_pkg::word_t extend_load(input t08_pkg::word_t w,
                                               input t08_pkg::func3_t f3);
    t08_pkg::word_t v;
    case (f3)
        t08_pkg::F3_B, t08_pkg::F3_BU: v = w & 32'h0000_00ff;
        t08_pkg::F3_H, t08_pkg::F3_HU: v = w & 32'h0000_ffff;
        default:                       v = w; // whole word
    endcase
    if (f3 == t08_pkg::F3_B && v[7]) v = v | 32'hffff_ff00;
    if (f3 == t08_pkg::F3_H && v[15]) v = v | 32'hffff_0000;
    return v;
endfunction

function automatic t08_pkg::word_t model_read(input t08_pkg::word_t a);
    if (a < t08_pkg::SRAM_LIMIT) return model_mem[a[10:2]]; // byte bits ignored
    if (a == t08_pkg::I2C_ADDRESS) return model_periph;
    return '0; // unmapped reads as zero
endfunction

// merge the enabled lanes, unmapped writes vanish
task automatic model_write(input t08_pkg::word_t a, input t08_pkg::word_t d,
                           input t08_pkg::func3_t f3);
    t08_pkg::word_t m;
    m = lane_mask(f3);
    if (a < t08_pkg::SRAM_LIMIT) begin
        model_mem[a[10:2]] = (model_mem[a[10:2]] & ~m) | (d & m);
    end else if (a == t08_pkg::I2C_ADDRESS) begin
        model_periph = (model_periph & ~m) | (d & m);
    end
endtask

`endif

// File: bench/t08_mem_tb.sv
// **********************************************************************
// t08 memory path testbench
// random fetch, load and store steps against ram, peripheral and
// unmapped space, compared with a behavioural model
// **********************************************************************

`timescale 1ns/1ps

module t08_mem_tb;

    localparam int NUM_STEPS = 300;
    localparam int TIMEOUT   = 64; // cycles allowed per wait

    logic            clk;
    logic            nrst;
    logic            write;
    logic            read;
    t08_pkg::func3_t func3;
    t08_pkg::word_t  fromregister;
    t08_pkg::word_t  mem_address;
    t08_pkg::word_t  counter;
    t08_pkg::word_t  toreg;
    t08_pkg::word_t  instruction;
    logic            inst_valid;
    logic            step_done;
    logic            freeze;

    int              errors;
    int              failed_tests;
    bit              timed_out;
    bit              lw_next;    // read back the last store
    t08_pkg::word_t  store_addr; // address of that store
    t08_pkg::word_t  pc_hint;    // last ram store, reused as pc
    t08_pkg::word_t  exp_toreg;  // toreg keeps its value between loads

    `include "t08_mem_model.svh"

    t08_mem_top #(
        .SRAM_WAIT   (2),
        .SRAM_WORDS  (512),
        .PERIPH_WAIT (5)
    ) UUT (
        .clk          (clk),
        .nrst         (nrst),
        .write        (write),
        .read         (read),
        .func3        (func3),
        .fromregister (fromregister),
        .mem_address  (mem_address),
        .counter      (counter),
        .toreg        (toreg),
        .instruction  (instruction),
        .inst_valid   (inst_valid),
        .step_done    (step_done),
        .freeze       (freeze)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // fetch phase of a step, freeze stays high throughout
    task automatic wait_inst(input string name, output bit ok, output bit bad);
        ok  = 1'b0;
        bad = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge clk);
            ok = inst_valid;
            if (freeze !== 1'b1) begin
                $display("FAIL %s freeze expected 1 actual %b", name, freeze);
                errors++;
                bad = 1'b1;
            end
        end
    endtask

    // data phase of a step, freeze drops only in the step_done cycle
    task automatic wait_step(input string name, output bit ok, output bit bad);
        ok  = 1'b0;
        bad = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge clk);
            ok = step_done;
            if (freeze !== !ok) begin
                $display("FAIL %s freeze expected %b actual %b", name, !ok, freeze);
                errors++;
                bad = 1'b1;
            end
            if (inst_valid !== 1'b0) begin
                $display("FAIL %s inst_valid expected 0 actual %b", name, inst_valid);
                errors++;
                bad = 1'b1;
            end
        end
    endtask

    // next step inputs held until its step_done
    task automatic pick_step();
        t08_pkg::word_t op;
        t08_pkg::word_t tgt;
        t08_pkg::word_t addr;
        t08_pkg::word_t sel;
        op  = rand_bits(2);
        tgt = rand_bits(3);
        case (tgt)
            32'd0:   addr = t08_pkg::I2C_ADDRESS;
            32'd1:   addr = 32'h0010_0000 + rand_bits(16); // unmapped space above periph
            default: begin
                addr = rand_bits(6) << 2;   // low ram
                addr = addr | rand_bits(2); // byte offset is ignored
            end
        endcase
        sel          = rand_bits(2);
        counter      = (sel == 32'd0) ? pc_hint : (rand_bits(9) << 2);
        fromregister = rand_bits(32);
        if (lw_next) begin
            write       = 1'b0; // LW right after a store
            read        = 1'b1;
            func3       = t08_pkg::F3_W;
            mem_address = store_addr;
            lw_next     = 1'b0;
        end else if (op == 32'd1) begin
            sel         = rand_bits(2);
            write       = 1'b1;
            read        = 1'b0;
            func3       = (sel == 32'd0) ? t08_pkg::F3_B :
                          (sel == 32'd1) ? t08_pkg::F3_H : t08_pkg::F3_W;
            mem_address = addr;
            store_addr  = addr;
            lw_next     = 1'b1;
            if (addr < t08_pkg::SRAM_LIMIT) pc_hint = {addr[31:2], 2'b00};
        end else begin
            write       = 1'b0;
            read        = (op != 32'd0); // op 0 is a plain fetch
            func3       = t08_pkg::func3_t'(rand_bits(3)); // unused codes load the whole word
            mem_address = addr;
        end
    endtask

    initial begin
        int             step;
        bit             ok;
        bit             bad;
        bit             step_bad;
        string          name;
        t08_pkg::word_t exp_inst;
        nrst         = 1'b0;
        write        = 1'b0;
        read         = 1'b0;
        func3        = '0;
        fromregister = '0;
        mem_address  = '0;
        counter      = '0;
        lfsr_q       = 16'd83;
        errors       = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        lw_next      = 1'b0;
        store_addr   = '0;
        pc_hint      = '0;
        exp_toreg    = '0;
        model_periph = '0;
        for (int w = 0; w < 512; w++) begin
            model_mem[w] = '0; // ram resets to zero
        end
        repeat (2) begin
            @(negedge clk);
            if (freeze !== 1'b1) begin
                $display("FAIL reset freeze expected 1 actual %b", freeze);
                errors++;
            end
        end
        pick_step(); // first fetch starts right after reset
        nrst = 1'b1;
        for (step = 0; step < NUM_STEPS && !timed_out; step++) begin
            name     = $sformatf("step%0d_%s_f%0d_%h", step,
                                 write ? "store" : (read ? "load" : "none"),
                                 func3, mem_address);
            exp_inst = model_mem[counter[10:2]]; // fetch sees earlier stores
            wait_inst(name, ok, bad);
            step_bad = bad;
            if (!ok) begin
                $display("%s: no instruction fetch finished within %0d cycles",
                         name, TIMEOUT);
                timed_out = 1'b1;
            end else begin
                if (instruction !== exp_inst) begin
                    $display("FAIL %s instruction expected %h actual %h",
                             name, exp_inst, instruction);
                    errors++;
                    step_bad = 1'b1;
                end
                wait_step(name, ok, bad);
                if (bad) step_bad = 1'b1;
                if (!ok) begin
                    $display("%s: data access did not finish within %0d cycles",
                             name, TIMEOUT);
                    timed_out = 1'b1;
                end else begin
                    if (read && !write) begin
                        exp_toreg = extend_load(model_read(mem_address), func3);
                    end
                    if (toreg !== exp_toreg) begin
                        $display("FAIL %s toreg expected %h actual %h", name, exp_toreg, toreg);
                        errors++;
                        step_bad = 1'b1;
                    end
                    if (write) model_write(mem_address, fromregister, func3);
                end
            end
            if (step_bad || timed_out) begin
                failed_tests++;
                $display("%s: failed", name);
            end else begin
                $display("%s: ok", name);
            end
            if (!timed_out) pick_step(); // still inside the step_done cycle
        end
        $display("steps %0d, failed %0d, errors %0d", step, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/t08_mem_top.sv
// **********************************************************************
// t08 memory subsystem top
// handler, address decoder, ram and peripheral register
// **********************************************************************

`timescale 1ns/1ps

module t08_mem_top #(
    parameter int SRAM_WAIT   = 2,
    parameter int SRAM_WORDS  = 512,
    parameter int PERIPH_WAIT = 5
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            write,
    input  logic            read,
    input  t08_pkg::func3_t func3,
    input  t08_pkg::word_t  fromregister,
    input  t08_pkg::word_t  mem_address,
    input  t08_pkg::word_t  counter,
    output t08_pkg::word_t  toreg,
    output t08_pkg::word_t  instruction,
    output logic            inst_valid,
    output logic            step_done,
    output logic            freeze
);

    t08_pkg::mem_req_t bus_req;    // handler to decoder
    t08_pkg::mem_rsp_t bus_rsp;
    t08_pkg::mem_req_t sram_req;
    t08_pkg::mem_rsp_t sram_rsp;
    t08_pkg::mem_req_t periph_req;
    t08_pkg::mem_rsp_t periph_rsp;

    t08_handler u_handler (
        .clk          (clk),
        .nrst         (nrst),
        .write        (write),
        .read         (read),
        .func3        (func3),
        .fromregister (fromregister),
        .mem_address  (mem_address),
        .counter      (counter),
        .bus_rsp      (bus_rsp),
        .bus_req      (bus_req),
        .toreg        (toreg),
        .instruction  (instruction),
        .inst_valid   (inst_valid),
        .step_done    (step_done),
        .freeze       (freeze)
    );

    t08_mem_decode u_decode (
        .clk        (clk),
        .nrst       (nrst),
        .cpu_req    (bus_req),
        .cpu_rsp    (bus_rsp),
        .sram_req   (sram_req),
        .sram_rsp   (sram_rsp),
        .periph_req (periph_req),
        .periph_rsp (periph_rsp)
    );

    t08_sram #(
        .SRAM_WORDS (SRAM_WORDS),
        .SRAM_WAIT  (SRAM_WAIT)
    ) u_sram (
        .clk  (clk),
        .nrst (nrst),
        .req  (sram_req),
        .rsp  (sram_rsp)
    );

    t08_periph_reg #(
        .PERIPH_WAIT (PERIPH_WAIT)
    ) u_periph (
        .clk  (clk),
        .nrst (nrst),
        .req  (periph_req),
        .rsp  (periph_rsp)
    );

endmodule

// File: src/t08_mem_decode.sv
// **********************************************************************
// t08 address decoder
// steers each access to ram, peripheral or a one-cycle default
// responder and returns the selected response
// **********************************************************************

`timescale 1ns/1ps

module t08_mem_decode (
    input  logic              clk,
    input  logic              nrst,
    input  t08_pkg::mem_req_t cpu_req,
    output t08_pkg::mem_rsp_t cpu_rsp,
    output t08_pkg::mem_req_t sram_req,
    input  t08_pkg::mem_rsp_t sram_rsp,
    output t08_pkg::mem_req_t periph_req,
    input  t08_pkg::mem_rsp_t periph_rsp
);

    localparam logic [1:0] SEL_NONE   = 2'd0;
    localparam logic [1:0] SEL_SRAM   = 2'd1;
    localparam logic [1:0] SEL_PERIPH = 2'd2;
    localparam logic [1:0] SEL_DFLT   = 2'd3; // unmapped

    logic              strobe;
    logic              hit_sram;
    logic              hit_periph;
    logic [1:0]        sel_q;  // target of the access in flight
    logic              dflt_q; // default responder done
    t08_pkg::mem_rsp_t dflt_rsp;

    assign strobe     = cpu_req.rd || cpu_req.wr;
    assign hit_sram   = cpu_req.addr < t08_pkg::SRAM_LIMIT;
    assign hit_periph = cpu_req.addr == t08_pkg::I2C_ADDRESS;

    // pass payload through, gate strobes per target
    always_comb begin
        sram_req      = cpu_req;
        sram_req.rd   = cpu_req.rd && hit_sram;
        sram_req.wr   = cpu_req.wr && hit_sram;
        periph_req    = cpu_req;
        periph_req.rd = cpu_req.rd && hit_periph;
        periph_req.wr = cpu_req.wr && hit_periph;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sel_q  <= SEL_NONE;
            dflt_q <= 1'b0;
        end else begin
            dflt_q <= strobe && !hit_sram && !hit_periph; // answer next cycle
            if (strobe) begin
                if (hit_sram)        sel_q <= SEL_SRAM;
                else if (hit_periph) sel_q <= SEL_PERIPH;
                else                 sel_q <= SEL_DFLT;
            end else if (cpu_rsp.done) begin
                sel_q <= SEL_NONE;
            end
        end
    end

    // unmapped reads give zero, writes vanish
    always_comb begin
        dflt_rsp.rdata = '0;
        dflt_rsp.busy  = dflt_q;
        dflt_rsp.done  = dflt_q;
    end

    always_comb begin
        case (sel_q)
            SEL_SRAM:   cpu_rsp = sram_rsp;
            SEL_PERIPH: cpu_rsp = periph_rsp;
            SEL_DFLT:   cpu_rsp = dflt_rsp;
            default:    cpu_rsp = '0; // idle
        endcase
    end

    // a target only completes the access it was given
    a_done_from_sel: assert property (@(posedge clk) disable iff (!nrst)
        !(sram_rsp.done && sel_q != SEL_SRAM) &&
        !(periph_rsp.done && sel_q != SEL_PERIPH));

endmodule

// File: src/t08_periph_reg.sv
// **********************************************************************
// t08 peripheral register
// one 32-bit word at the i2c address, answers after a slow delay
// **********************************************************************

`timescale 1ns/1ps

module t08_periph_reg #(
    parameter int PERIPH_WAIT = 5 // cycles from strobe to done, >= 1
) (
    input  logic              clk,
    input  logic              nrst,
    input  t08_pkg::mem_req_t req,
    output t08_pkg::mem_rsp_t rsp
);

    localparam int CNT_W = $clog2(PERIPH_WAIT + 1);

    t08_pkg::word_t   reg_q;  // the register itself
    logic [CNT_W-1:0] cnt_q;  // counts up from 1 after strobe
    logic             busy_q;
    logic             wr_q;
    logic             expire; // delay reached

    assign expire = busy_q && (cnt_q == CNT_W'(PERIPH_WAIT));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cnt_q  <= '0;
            busy_q <= 1'b0;
            wr_q   <= 1'b0;
        end else if (req.rd || req.wr) begin
            cnt_q  <= CNT_W'(1);
            busy_q <= 1'b1;
            wr_q   <= req.wr;
        end else if (expire) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // lane update once the delay has run out
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            reg_q <= '0;
        end else if (expire && wr_q) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) reg_q[8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    assign rsp.rdata = reg_q;
    assign rsp.busy  = busy_q;
    assign rsp.done  = expire;

endmodule

// File: src/memory/t08_sram.sv
// **********************************************************************
// t08 data/instruction ram
// word organised, byte enabled, fixed number of wait states per access
// **********************************************************************

`timescale 1ns/1ps

module t08_sram #(
    parameter int SRAM_WORDS = 512,
    parameter int SRAM_WAIT  = 2    // cycles from strobe to done, >= 1
) (
    input  logic              clk,
    input  logic              nrst,
    input  t08_pkg::mem_req_t req,
    output t08_pkg::mem_rsp_t rsp
);

    localparam int IDX_W = $clog2(SRAM_WORDS);
    localparam int CNT_W = $clog2(SRAM_WAIT + 1);

    t08_pkg::word_t   mem [SRAM_WORDS];
    logic [IDX_W-1:0] idx_q;  // captured word index
    logic [CNT_W-1:0] cnt_q;  // cycles left before done
    logic             busy_q;
    logic             wr_q;   // access is a write
    logic             strobe;
    logic             last;   // final count, done cycle

    assign strobe = req.rd || req.wr;
    assign last   = busy_q && (cnt_q == '0);

    // wait state counter
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            idx_q  <= '0;
            cnt_q  <= '0;
            busy_q <= 1'b0;
            wr_q   <= 1'b0;
        end else if (strobe) begin
            idx_q  <= req.addr[IDX_W+1:2]; // word address, byte bits dropped
            cnt_q  <= CNT_W'(SRAM_WAIT - 1);
            busy_q <= 1'b1;
            wr_q   <= req.wr;
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // array, lane writes on the final count
    // wdata and be are held by the requester until done
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int w = 0; w < SRAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (last && wr_q) begin
            for (int b = 0; b < 4; b++) begin
                if (req.be[b]) begin
                    mem[idx_q][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rsp.rdata = mem[idx_q]; // only sampled with done
    assign rsp.busy  = busy_q;
    assign rsp.done  = last;

    // decoder must not forward a strobe into a running access
    a_sram_no_overlap: assert property (@(posedge clk) disable iff (!nrst)
        strobe |-> !busy_q);

endmodule

// File: src/handler/t08_handler.sv
// **********************************************************************
// t08 memory handler
// per processor step: instruction fetch at counter, then at most one
// load or store, with store lane formatting and load extension
// **********************************************************************

`timescale 1ns/1ps

module t08_handler (
    input  logic              clk,
    input  logic              nrst,
    input  logic              write,        // store this step
    input  logic              read,         // load this step
    input  t08_pkg::func3_t   func3,
    input  t08_pkg::word_t    fromregister, // store source
    input  t08_pkg::word_t    mem_address,  // data address
    input  t08_pkg::word_t    counter,      // program counter
    input  t08_pkg::mem_rsp_t bus_rsp,
    output t08_pkg::mem_req_t bus_req,
    output t08_pkg::word_t    toreg,        // load result
    output t08_pkg::word_t    instruction,
    output logic              inst_valid,
    output logic              step_done,
    output logic              freeze
);

    t08_pkg::handler_state_t state;
    t08_pkg::mem_req_t       req_q;      // registered bus request
    logic                    fetch_sent; // fetch strobe already issued
    t08_pkg::byte_en_t       store_be;
    t08_pkg::word_t          load_val;
    logic                    is_store;
    logic                    is_load;

    // write wins if both are set
    assign is_store = write;
    assign is_load  = read && !write;

    // store data always sits in the low lanes
    always_comb begin
        case (func3)
            t08_pkg::F3_B: store_be = 4'b0001; // SB
            t08_pkg::F3_H: store_be = 4'b0011; // SH
            default:       store_be = 4'b1111; // SW and anything else
        endcase
    end

    // load extension from the low byte or half of the returned word
    always_comb begin
        case (func3)
            t08_pkg::F3_B: begin
                load_val = {{24{bus_rsp.rdata[7]}}, bus_rsp.rdata[7:0]};   // LB
            end
            t08_pkg::F3_H: begin
                load_val = {{16{bus_rsp.rdata[15]}}, bus_rsp.rdata[15:0]}; // LH
            end
            t08_pkg::F3_BU: load_val = {24'b0, bus_rsp.rdata[7:0]};  // LBU
            t08_pkg::F3_HU: load_val = {16'b0, bus_rsp.rdata[15:0]}; // LHU
            default:        load_val = bus_rsp.rdata;               // LW and the rest
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= t08_pkg::ST_FETCH;
            fetch_sent  <= 1'b0;
            req_q       <= '0;
            toreg       <= '0;
            instruction <= '0;
            inst_valid  <= 1'b0;
            step_done   <= 1'b0;
        end else begin
            // strobes and pulses last one cycle
            req_q.rd   <= 1'b0;
            req_q.wr   <= 1'b0;
            inst_valid <= 1'b0;
            step_done  <= 1'b0;

            case (state)
                t08_pkg::ST_FETCH: begin
                    if (!fetch_sent && !bus_rsp.busy) begin
                        req_q.addr <= counter; // fetch at pc
                        req_q.be   <= 4'b1111;
                        req_q.rd   <= 1'b1;
                        fetch_sent <= 1'b1;
                    end else if (fetch_sent && bus_rsp.done) begin
                        instruction <= bus_rsp.rdata;
                        inst_valid  <= 1'b1;
                        fetch_sent  <= 1'b0;
                        state       <= t08_pkg::ST_DATA_REQ;
                    end
                end

                t08_pkg::ST_DATA_REQ: begin
                    if (!is_store && !is_load) begin
                        // no data access so the step ends here
                        step_done <= 1'b1;
                        state     <= t08_pkg::ST_FETCH;
                    end else begin
                        req_q.addr  <= mem_address;
                        req_q.wdata <= fromregister;          // lanes pick the bytes
                        req_q.be    <= is_store ? store_be : 4'b1111;
                        req_q.wr    <= is_store;
                        req_q.rd    <= is_load;
                        state       <= t08_pkg::ST_DATA_WAIT;
                    end
                end

                t08_pkg::ST_DATA_WAIT: begin
                    if (bus_rsp.done) begin
                        if (is_load) begin
                            toreg <= load_val; // only loads touch toreg
                        end
                        step_done <= 1'b1;
                        state     <= t08_pkg::ST_FETCH;
                    end
                end

                default: state <= t08_pkg::ST_FETCH;
            endcase
        end
    end

    assign bus_req = req_q;
    assign freeze  = ~step_done; // core runs only in the step_done cycle

    // the bus never sees a new strobe while a target is busy
    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!nrst)
        (bus_req.rd || bus_req.wr) |-> !bus_rsp.busy);

    // read and write strobes are exclusive
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(bus_req.rd && bus_req.wr));

endmodule

// File: common/t08_pkg.sv
// **********************************************************************
// t08 memory path shared definitions
// word and lane types, func3 codes, handler states, bus structs
// and the fixed address map of the subsystem
// **********************************************************************

package t08_pkg;

    // basic vectors
    typedef logic [31:0] word_t;    // data, address, instruction
    typedef logic [2:0]  func3_t;   // access size and sign
    typedef logic [3:0]  byte_en_t; // one bit per byte lane

    // func3 codes for loads and stores
    localparam func3_t F3_B  = 3'd0; // byte, signed on load
    localparam func3_t F3_H  = 3'd1; // half, signed on load
    localparam func3_t F3_W  = 3'd2; // full word
    localparam func3_t F3_BU = 3'd4; // byte, zero extended
    localparam func3_t F3_HU = 3'd5; // half, zero extended

    // address map
    localparam word_t I2C_ADDRESS = 32'd923923; // single peripheral word
    localparam word_t SRAM_LIMIT  = 32'd2048;   // ram lives below this

    // handler sequencer states
    typedef enum logic [1:0] {
        ST_FETCH,     // instruction fetch at counter
        ST_DATA_REQ,  // decide and issue the data access
        ST_DATA_WAIT  // data access in flight
    } handler_state_t;

    // request from handler towards a target, 70 bits
    typedef struct packed {
        word_t    addr;  // word address, bits 1:0 ignored
        word_t    wdata; // store data, low lanes used
        byte_en_t be;    // lane enables for writes
        logic     rd;    // one-cycle read strobe
        logic     wr;    // one-cycle write strobe
    } mem_req_t;

    // response from a target, 34 bits
    typedef struct packed {
        word_t rdata; // valid with done
        logic  busy;  // access in progress
        logic  done;  // one-cycle completion pulse
    } mem_rsp_t;

endpackage
